/* Makefile */
# Verilator build and run of the Booth multiplier testbench

SRCS := project.f $(wildcard design/*.sv bench/*.sv bench/*.svh)

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source or the file list changes
obj_dir/Vmul_tb: $(SRCS)
	verilator --binary --timing --top-module mul_tb -f project.f

# pass only if the pass line shows up in the output
run: obj_dir/Vmul_tb
	@out="$$(./obj_dir/Vmul_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

/* bench/mul_ref.svh */
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

//************************************************************
// expected product
//************************************************************

// full product as {hi, lo}
// each operand extended by its own sign bit, product taken mod 2^128
function automatic logic [2*XLEN-1:0] ref_product(input xlen_t a, input xlen_t b,
	input logic w, input sign_mode_t s);
	logic [2*XLEN-1:0] a_ext;
	logic [2*XLEN-1:0] b_ext;
	logic [2*XLEN-1:0] full;
	xlen_t             a_w;
	xlen_t             b_w;
	xlen_t             prod_w;
	if (w) begin
		// low words only, upper input bits ignored
		a_w = s[1] ? {{(XLEN - WORD_W){a[WORD_W-1]}}, a[WORD_W-1:0]} :
			{{(XLEN - WORD_W){1'b0}}, a[WORD_W-1:0]};
		b_w = s[0] ? {{(XLEN - WORD_W){b[WORD_W-1]}}, b[WORD_W-1:0]} :
			{{(XLEN - WORD_W){1'b0}}, b[WORD_W-1:0]};
		prod_w = a_w * b_w;
		// bit 31 copied over everything above the low word
		full = {{XLEN{prod_w[WORD_W-1]}}, {(XLEN - WORD_W){prod_w[WORD_W-1]}},
			prod_w[WORD_W-1:0]};
	end else begin
		a_ext = s[1] ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
		b_ext = s[0] ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
		// truncating multiply is exact mod 2^128
		full = a_ext * b_ext;
	end
	return full;
endfunction

//************************************************************
// compare tasks
//************************************************************

// one result half
task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
	if (got !== exp) begin
		abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	end
endtask

// single-bit handshake signal
task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	end
endtask

`endif

/* bench/mul_tb.sv */
`timescale 1ns/1ns

module mul_tb import mul_pkg::*; ();

	// test counts
	localparam int N_CORNER  = 5;
	localparam int N_RAND    = 8;
	localparam int N_B2B     = 20;
	localparam int N_FLUSH   = 8;
	// two widths, four sign modes, corner pairs plus random; flush tests issue twice
	localparam int NUM_TESTS = 2 * 4 * (N_CORNER * N_CORNER + N_RAND) + N_B2B + 2 * N_FLUSH;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 200;

	// one outstanding result and the cycle it is due in
	typedef struct {
		xlen_t       hi;
		xlen_t       lo;
		int unsigned due;
	} expect_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        mul_valid;
	logic        flush;
	logic        mulw;
	sign_mode_t  mul_signed;
	xlen_t       multiplicand;
	xlen_t       multiplier;
	logic        mul_ready;
	logic        out_valid;
	xlen_t       result_hi;
	xlen_t       result_lo;
	int unsigned cyc = 0;
	expect_t     pending[$];

	mul_top dut0 (
		.clk          (clk),
		.rst          (rst),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	// stop the run with a reason
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	`include "mul_ref.svh"

	// 100 ns period
	always #50 clk = ~clk;

	// cycle count and watchdog
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout, run did not end within %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	//************************************************************
	// result monitor
	//************************************************************

	// outputs only move on posedge, so negedge sees them settled
	always @(negedge clk) begin
		if (!rst) begin
			if ((pending.size() != 0) && (pending[0].due == cyc)) begin
				check_flag("out_valid", out_valid, 1'b1);
				// ready comes back together with the pulse
				check_flag("mul_ready", mul_ready, 1'b1);
				check_xlen("result_hi", result_hi, pending[0].hi);
				check_xlen("result_lo", result_lo, pending[0].lo);
				void'(pending.pop_front());
			end else begin
				// any pulse outside a due cycle is extra
				check_flag("out_valid", out_valid, 1'b0);
			end
		end
	end

	//************************************************************
	// stimulus helpers
	//************************************************************

	function automatic xlen_t rand_xlen();
		return {$urandom, $urandom};
	endfunction

	// 0, 1, all ones, most negative, most positive
	function automatic xlen_t corner64(input int i);
		case (i)
			0: return '0;
			1: return xlen_t'(1);
			2: return '1;
			3: return {1'b1, {(XLEN - 1){1'b0}}};
			default: return {1'b0, {(XLEN - 1){1'b1}}};
		endcase
	endfunction

	// same corners on the low word, junk above
	function automatic xlen_t corner32(input int i);
		logic [WORD_W-1:0] lo;
		case (i)
			0: lo = '0;
			1: lo = 32'd1;
			2: lo = '1;
			3: lo = 32'h8000_0000;
			default: lo = 32'h7fff_ffff;
		endcase
		return {$urandom, lo};
	endfunction

	// caller sits at a negedge; request accepted on the next posedge
	task automatic issue(input xlen_t a, input xlen_t b, input logic w,
		input sign_mode_t s, input logic keep);
		expect_t           e;
		logic [2*XLEN-1:0] p;
		while (mul_ready !== 1'b1) @(negedge clk);
		multiplicand = a;
		multiplier   = b;
		mulw         = w;
		mul_signed   = s;
		mul_valid    = 1'b1;
		p     = ref_product(a, b, w, s);
		e.hi  = p[2*XLEN-1:XLEN];
		e.lo  = p[XLEN-1:0];
		// 33 or 17 cycles after the accepting edge
		e.due = cyc + 1 + int'(w ? STEPS_WORD : STEPS_DWORD);
		// flushed requests leave nothing to check
		if (keep) begin
			pending.push_back(e);
		end
		@(negedge clk);
		mul_valid = 1'b0;
	endtask

	// idle until ready, with optional junk requests while busy
	task automatic wait_ready(input logic poke);
		while (mul_ready !== 1'b1) begin
			if (poke && ($urandom_range(0, 2) == 0)) begin
				multiplicand = rand_xlen();
				multiplier   = rand_xlen();
				mulw         = ($urandom_range(0, 1) == 1);
				mul_signed   = sign_mode_t'($urandom_range(0, 3));
				mul_valid    = 1'b1;
			end else begin
				mul_valid = 1'b0;
			end
			@(negedge clk);
		end
		mul_valid = 1'b0;
	endtask

	// abort at a random busy cycle, then a normal request
	task automatic flush_one();
		logic        w;
		int unsigned r;
		w = ($urandom_range(0, 1) == 1);
		issue(rand_xlen(), rand_xlen(), w, sign_mode_t'($urandom_range(0, 3)), 1'b0);
		// last legal flush is the cycle before out_valid would rise
		r = $urandom_range(0, (w ? STEPS_WORD : STEPS_DWORD) - 1);
		repeat (r) @(negedge clk);
		check_flag("mul_ready", mul_ready, 1'b0);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		check_flag("mul_ready", mul_ready, 1'b1);
		issue(rand_xlen(), rand_xlen(), w, sign_mode_t'($urandom_range(0, 3)), 1'b1);
		wait_ready(1'b0);
	endtask

	//************************************************************
	// test sequence
	//************************************************************

	initial begin
		void'($urandom(32'hf427));
		rst          = 1'b1;
		mul_valid    = 1'b0;
		flush        = 1'b0;
		mulw         = 1'b0;
		mul_signed   = '0;
		multiplicand = '0;
		multiplier   = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// state right after reset
		check_flag("mul_ready", mul_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		check_xlen("result_hi", result_hi, '0);
		check_xlen("result_lo", result_lo, '0);
		// 64-bit sweep over sign modes
		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < N_CORNER; i++) begin
				for (int j = 0; j < N_CORNER; j++) begin
					issue(corner64(i), corner64(j), 1'b0, sign_mode_t'(m), 1'b1);
					wait_ready(1'b0);
				end
			end
			for (int i = 0; i < N_RAND; i++) begin
				issue(rand_xlen(), rand_xlen(), 1'b0, sign_mode_t'(m), 1'b1);
				wait_ready(1'b0);
			end
		end
		// word mode, junk in the upper halves
		for (int m = 0; m < 4; m++) begin
			for (int i = 0; i < N_CORNER; i++) begin
				for (int j = 0; j < N_CORNER; j++) begin
					issue(corner32(i), corner32(j), 1'b1, sign_mode_t'(m), 1'b1);
					wait_ready(1'b0);
				end
			end
			for (int i = 0; i < N_RAND; i++) begin
				issue(rand_xlen(), rand_xlen(), 1'b1, sign_mode_t'(m), 1'b1);
				wait_ready(1'b0);
			end
		end
		// back to back, mul_valid poked while busy
		for (int i = 0; i < N_B2B; i++) begin
			issue(rand_xlen(), rand_xlen(), ($urandom_range(0, 1) == 1),
				sign_mode_t'($urandom_range(0, 3)), 1'b1);
			wait_ready(1'b1);
		end
		for (int i = 0; i < N_FLUSH; i++) begin
			flush_one();
		end
		// let the last due cycle pass
		repeat (2) @(negedge clk);
		if (pending.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			abort_run("results still outstanding at the end of the run");
		end
	end

endmodule

/* design/booth_recoder.sv */
`timescale 1ns/1ns

module booth_recoder import mul_pkg::*; (
	input  logic [2:0] triplet,
	input  prod_t      mcand_shifted,
	output prod_t      partial
);

	// digit magnitude and sign
	logic  one;
	logic  two;
	logic  neg;
	prod_t mag;

	//************************************************************
	// radix-4 digit decode
	//************************************************************

	// triplet is {b(2i+1), b(2i), b(2i-1)}
	always_comb begin
		one = 1'b0;
		two = 1'b0;
		neg = 1'b0;
		case (triplet)
			3'b001, 3'b010: begin
				// digit +1
				one = 1'b1;
			end
			3'b011: begin
				// digit +2
				two = 1'b1;
			end
			3'b100: begin
				// digit -2
				two = 1'b1;
				neg = 1'b1;
			end
			3'b101, 3'b110: begin
				// digit -1
				one = 1'b1;
				neg = 1'b1;
			end
			default: begin
				// 000 and 111 give zero
				one = 1'b0;
			end
		endcase
	end

	// magnitude, doubled by a one bit shift
	assign mag = two ? {mcand_shifted[PROD_W-2:0], 1'b0} :
		one ? mcand_shifted : '0;

	// two's complement for negative digits
	assign partial = neg ? (~mag + prod_t'(1)) : mag;

endmodule

/* design/mul_ctrl.sv */
`timescale 1ns/1ns

module mul_ctrl import mul_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic mul_valid,
	input  logic flush,
	input  logic mulw,
	output logic mul_ready,
	output logic out_valid,
	output logic load,
	output logic step_en,
	output logic word_mode
);

	mul_state_t state;

	// steps still to go, zero on the last one
	step_cnt_t  cnt;

	// word mode of the request in flight
	logic       word_q;

	// request taken on this edge
	logic       accept;

	//************************************************************
	// handshake
	//************************************************************

	// ready exactly when idle
	assign mul_ready = (state == MUL_IDLE);

	// flush wins over a new request
	assign accept = mul_valid & mul_ready & ~flush;

	// datapath loads on the accepting edge
	assign load = accept;

	// stop stepping at once on flush so the datapath freezes
	assign step_en = (state == MUL_BUSY) & ~flush;

	// datapath needs the new mode during the load itself
	assign word_mode = accept ? mulw : word_q;

	//************************************************************
	// state machine and step counter
	//************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= MUL_IDLE;
			cnt       <= '0;
			word_q    <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			// single-cycle pulse by default
			out_valid <= 1'b0;
			case (state)
				MUL_IDLE: begin
					if (accept) begin
						state  <= MUL_BUSY;
						word_q <= mulw;
						// budget picked by the request mode
						cnt    <= mulw ? step_cnt_t'(STEPS_WORD - 1) :
							step_cnt_t'(STEPS_DWORD - 1);
					end
				end
				MUL_BUSY: begin
					if (flush) begin
						// abandon, no result pulse
						state <= MUL_IDLE;
					end else if (cnt == '0) begin
						// last step retires on this edge
						state     <= MUL_IDLE;
						out_valid <= 1'b1;
					end else begin
						cnt <= cnt - step_cnt_t'(1);
					end
				end
				default: begin
					state <= MUL_IDLE;
				end
			endcase
		end
	end

endmodule

/* design/mul_datapath.sv */
`timescale 1ns/1ns

module mul_datapath import mul_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       load,
	input  logic       step_en,
	input  logic       word_mode,
	input  sign_mode_t mul_signed,
	input  xlen_t      multiplicand,
	input  xlen_t      multiplier,
	output xlen_t      result_hi,
	output xlen_t      result_lo
);

	// extend one operand to OPND_W bits
	// word mode keeps only the low 32 bits
	function automatic opnd_t extend_opnd(input xlen_t val, input logic sgn,
		input logic word);
		logic fill;
		begin
			if (word) begin
				fill = sgn & val[WORD_W-1];
				extend_opnd = {{(OPND_W - WORD_W){fill}}, val[WORD_W-1:0]};
			end else begin
				fill = sgn & val[XLEN-1];
				extend_opnd = {{(OPND_W - XLEN){fill}}, val};
			end
		end
	endfunction

	// extended operands, valid on the load edge
	opnd_t             mcand_ext;
	opnd_t             mplier_ext;

	// multiplicand, moves left two bits per step
	prod_t             mcand_q;

	// multiplier with guard bit below, moves right two bits per step
	logic [OPND_W:0]   mplier_q;

	// running sum of partial products
	prod_t             acc;

	// result shape of the last loaded request
	logic              word_res;

	// current booth partial product
	prod_t             partial;

	//************************************************************
	// operand extension
	//************************************************************

	assign mcand_ext  = extend_opnd(multiplicand, mul_signed[1], word_mode);
	assign mplier_ext = extend_opnd(multiplier, mul_signed[0], word_mode);

	//************************************************************
	// booth step
	//************************************************************

	booth_recoder booth0 (
		.triplet       (mplier_q[2:0]),
		.mcand_shifted (mcand_q),
		.partial       (partial)
	);

	// operand shift registers
	always_ff @(posedge clk) begin
		if (load) begin
			// sign-fill up to the full product width
			mcand_q  <= {{(PROD_W - OPND_W){mcand_ext[OPND_W-1]}}, mcand_ext};
			// zero guard bit for the first triplet
			mplier_q <= {mplier_ext, 1'b0};
		end else if (step_en) begin
			mcand_q  <= {mcand_q[PROD_W-3:0], 2'b00};
			mplier_q <= {2'b00, mplier_q[OPND_W:2]};
		end
	end

	// accumulator and result shape
	always_ff @(posedge clk) begin
		if (rst) begin
			acc      <= '0;
			word_res <= 1'b0;
		end else if (load) begin
			acc      <= '0;
			word_res <= word_mode;
		end else if (step_en) begin
			// wraps mod 2^PROD_W, low 128 bits stay exact
			acc <= acc + partial;
		end
	end

	//************************************************************
	// result shaping
	//************************************************************

	// word mode sign-extends bit 31 of the product
	always_comb begin
		if (word_res) begin
			result_hi = {XLEN{acc[WORD_W-1]}};
			result_lo = {{(XLEN - WORD_W){acc[WORD_W-1]}}, acc[WORD_W-1:0]};
		end else begin
			result_hi = acc[2*XLEN-1:XLEN];
			result_lo = acc[XLEN-1:0];
		end
	end

endmodule

/* design/mul_pkg.sv */
package mul_pkg;

	//************************************************************
	// widths
	//************************************************************

	// operand width of the core
	localparam int XLEN = 64;

	// word mode uses the low half of each operand
	localparam int WORD_W = 32;

	// two extra bits so unsigned operands stay positive in two's complement
	localparam int OPND_W = XLEN + 2;

	// full product of two extended operands
	localparam int PROD_W = 2 * OPND_W;

	//************************************************************
	// step budgets
	//************************************************************

	// radix-4, two multiplier bits retired per step
	localparam int STEPS_DWORD = OPND_W / 2;

	// 32-bit operands extended to 34 bits
	localparam int STEPS_WORD = (WORD_W + 2) / 2;

	//************************************************************
	// types
	//************************************************************

	// one operand, or one half of the result
	typedef logic [XLEN-1:0] xlen_t;

	// operand after sign or zero extension
	typedef logic [OPND_W-1:0] opnd_t;

	// accumulator, shifted multiplicand, partial product
	typedef logic [PROD_W-1:0] prod_t;

	// bit 1 multiplicand signed, bit 0 multiplier signed
	typedef logic [1:0] sign_mode_t;

	// remaining steps of the current multiplication
	typedef logic [5:0] step_cnt_t;

	// controller states
	typedef enum logic {
		MUL_IDLE,
		MUL_BUSY
	} mul_state_t;

endpackage

/* design/mul_top.sv */
`timescale 1ns/1ns

module mul_top import mul_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       mul_valid,
	input  logic       flush,
	input  logic       mulw,
	input  sign_mode_t mul_signed,
	input  xlen_t      multiplicand,
	input  xlen_t      multiplier,
	output logic       mul_ready,
	output logic       out_valid,
	output xlen_t      result_hi,
	output xlen_t      result_lo
);

	//************************************************************
	// controller to datapath
	//************************************************************

	logic load;
	logic step_en;
	logic word_mode;

	// handshake, step count, flush
	mul_ctrl ctrl0 (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mulw      (mulw),
		.mul_ready (mul_ready),
		.out_valid (out_valid),
		.load      (load),
		.step_en   (step_en),
		.word_mode (word_mode)
	);

	// booth iteration and result shaping
	mul_datapath dp0 (
		.clk          (clk),
		.rst          (rst),
		.load         (load),
		.step_en      (step_en),
		.word_mode    (word_mode),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

endmodule

/* project.f */
+incdir+bench
design/mul_pkg.sv
design/booth_recoder.sv
design/mul_ctrl.sv
design/mul_datapath.sv
design/mul_top.sv
bench/mul_tb.sv
